/* hw/bus_int_pkg.sv */
/*
 * Board bus housekeeping package
 * Shared widths, register map encodings and bus structures
 */
package bus_int_pkg;

   // --------------------
   // Bus and field widths
   // --------------------
   localparam int SET_AWIDTH   = 8;
   localparam int SET_DWIDTH   = 32;
   localparam int NUM_SFP      = 2;

   localparam int LED_W        = 8;
   localparam int SW_RST_W     = 4;
   localparam int CLK_CTRL_W   = 7;
   localparam int CLK_STATUS_W = 5;
   localparam int FIFO_FLAG_W  = 4;

   // Bit 6 turns the GPSDO on out of reset
   localparam logic [CLK_CTRL_W-1:0] CLK_CTRL_RESET = 7'b100_0000;

   // Compatibility number returned on readback
   localparam logic [15:0] COMPAT_MAJOR = 16'h0008;
   localparam logic [15:0] COMPAT_MINOR = 16'h0000;

   // --------------------
   // Register map
   // --------------------
   typedef enum logic [SET_AWIDTH-1:0] {
      SR_LEDS       = 8'd0,
      SR_SW_RST     = 8'd1,
      SR_CLOCK_CTRL = 8'd2,
      SR_SFPP_CTRL0 = 8'd8,
      SR_SFPP_CTRL1 = 8'd9,
      SR_FIFOFLAGS  = 8'd10
   } set_addr_e;

   typedef enum logic [SET_AWIDTH-1:0] {
      RB_COUNTER      = 8'd0,
      RB_CLK_STATUS   = 8'd3,
      RB_COMPAT_NUM   = 8'd6,
      RB_SFPP_STATUS0 = 8'd8,
      RB_SFPP_STATUS1 = 8'd9,
      RB_FIFOFLAGS    = 8'd10
   } rb_addr_e;

   // --------------------
   // Bus structures
   // --------------------
   // Settings write, strobe only
   typedef struct packed {
      logic                  stb;
      logic [SET_AWIDTH-1:0] addr;
      logic [SET_DWIDTH-1:0] data;
   } set_bus_t;

   // Raw status pins of one SFP+ cage
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   // Changed bits sit above the synchronized pin levels
   typedef struct packed {
      sfp_pins_t changed;
      sfp_pins_t current;
   } sfp_status_t;

endpackage

/* hw/settings_regs.sv */
/*
 * Settings register bank
 * Decodes settings writes into LED, soft reset, clock and SFP+ control
 */
`timescale 1ns/1ns

module settings_regs (
   input  logic                                           clk,
   input  logic                                           reset,
   input  bus_int_pkg::set_bus_t                          i_set,
   output logic [bus_int_pkg::LED_W-1:0]                  o_leds,
   output logic [bus_int_pkg::SW_RST_W-1:0]               o_sw_rst,
   output logic [bus_int_pkg::CLK_CTRL_W-1:0]             o_clock_control,
   output logic [bus_int_pkg::NUM_SFP-1:0][1:0]           o_sfpp_rs_drive_low,
   output logic                                           o_fifo_clear
);

   import bus_int_pkg::*;

   // Address seen as a register map entry
   // Unmapped values fall through to the default branch
   set_addr_e set_addr;

   assign set_addr = set_addr_e'(i_set.addr);

   // --------------------
   // Register bank
   // --------------------
   // Soft reset bits
   //   [0] PHY reset
   //   [1] radio clock domain reset
   //   [2] radio clock PLL reset
   //   [3] spare
   //
   // SFP+ rate select bits per cage
   //   [0] pull RS0 low
   //   [1] pull RS1 low
   always_ff @(posedge clk) begin
      if (reset) begin
         o_leds              <= '0;
         o_sw_rst            <= '0;
         o_clock_control     <= CLK_CTRL_RESET;
         o_sfpp_rs_drive_low <= '0;
         o_fifo_clear        <= 1'b0;
      end else begin
         // Clear request lasts one cycle
         o_fifo_clear <= 1'b0;

         if (i_set.stb) begin
            case (set_addr)
               SR_LEDS: begin
                  o_leds <= i_set.data[LED_W-1:0];
               end
               SR_SW_RST: begin
                  o_sw_rst <= i_set.data[SW_RST_W-1:0];
               end
               SR_CLOCK_CTRL: begin
                  o_clock_control <= i_set.data[CLK_CTRL_W-1:0];
               end
               SR_SFPP_CTRL0: begin
                  o_sfpp_rs_drive_low[0] <= i_set.data[1:0];
               end
               SR_SFPP_CTRL1: begin
                  o_sfpp_rs_drive_low[1] <= i_set.data[1:0];
               end
               // Data is ignored here
               SR_FIFOFLAGS: begin
                  o_fifo_clear <= 1'b1;
               end
               default: begin
               end
            endcase
         end
      end
   end

endmodule

/* hw/sfp_status_monitor.sv */
/*
 * SFP+ cage status monitor
 * Synchronizes the cage pins and latches any change until cleared
 */
`timescale 1ns/1ns

module sfp_status_monitor (
   input  logic                     clk,
   input  logic                     reset,
   input  bus_int_pkg::sfp_pins_t   i_pins,
   input  logic                     i_clear,
   output bus_int_pkg::sfp_status_t o_status
);

   import bus_int_pkg::*;

   // Two flop synchronizer on the raw pins
   sfp_pins_t pins_meta;
   sfp_pins_t pins_sync;
   // Sticky record of pins that moved
   sfp_pins_t changed;

   // Raw pins into the clk domain
   always_ff @(posedge clk) begin
      pins_meta <= i_pins;
      pins_sync <= pins_meta;
   end

   // --------------------
   // Change latch
   // --------------------
   // A bit sets when the stages disagree
   // Clear from the readback side wins
   always_ff @(posedge clk) begin
      if (reset) begin
         changed <= '0;
      end else if (i_clear) begin
         changed <= '0;
      end else begin
         changed <= changed | (pins_meta ^ pins_sync);
      end
   end

   assign o_status.changed = changed;
   assign o_status.current = pins_sync;

endmodule

/* hw/fault_flag_accum.sv */
/*
 * FIFO fault record
 * Keeps every active-low fault flag seen until cleared
 */
`timescale 1ns/1ns

module fault_flag_accum (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [bus_int_pkg::FIFO_FLAG_W-1:0] i_fifo_flags_n,
   input  logic                                i_clear,
   output logic [bus_int_pkg::FIFO_FLAG_W-1:0] o_flags
);

   import bus_int_pkg::*;

   // Flags asserted this cycle
   logic [FIFO_FLAG_W-1:0] flags_active;

   assign flags_active = ~i_fifo_flags_n;

   // Short FIFO glitches stay visible to a later read
   // Clear wins over a new flag in the same cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         o_flags <= '0;
      end else if (i_clear) begin
         o_flags <= '0;
      end else begin
         o_flags <= o_flags | flags_active;
      end
   end

endmodule

/* hw/readback_mux.sv */
/*
 * Readback port
 * Cycle counter, address decode and registered read data
 */
`timescale 1ns/1ns

module readback_mux (
   input  logic                                                 clk,
   input  logic                                                 reset,
   input  logic                                                 i_rb_stb,
   input  logic [bus_int_pkg::SET_AWIDTH-1:0]                   i_rb_addr,
   input  logic [bus_int_pkg::CLK_STATUS_W-1:0]                 i_clock_status,
   input  bus_int_pkg::sfp_status_t [bus_int_pkg::NUM_SFP-1:0]  i_sfp_status,
   input  logic [bus_int_pkg::FIFO_FLAG_W-1:0]                  i_fifo_flags,
   output logic                                                 o_rb_valid,
   output logic [bus_int_pkg::SET_DWIDTH-1:0]                   o_rb_data,
   output logic [bus_int_pkg::NUM_SFP-1:0]                      o_sfp_clear
);

   import bus_int_pkg::*;

   logic [SET_DWIDTH-1:0] counter;
   logic [SET_DWIDTH-1:0] rb_word;
   rb_addr_e              rb_addr;

   assign rb_addr = rb_addr_e'(i_rb_addr);

   // Free running cycle count
   always_ff @(posedge clk) begin
      if (reset) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   // --------------------
   // Address decode
   // --------------------
   // Narrow fields are zero extended
   always_comb begin
      case (rb_addr)
         RB_COUNTER:      rb_word = counter;
         RB_CLK_STATUS:   rb_word = SET_DWIDTH'(i_clock_status);
         RB_COMPAT_NUM:   rb_word = {COMPAT_MAJOR, COMPAT_MINOR};
         RB_SFPP_STATUS0: rb_word = SET_DWIDTH'(i_sfp_status[0]);
         RB_SFPP_STATUS1: rb_word = SET_DWIDTH'(i_sfp_status[1]);
         RB_FIFOFLAGS:    rb_word = SET_DWIDTH'(i_fifo_flags);
         default:         rb_word = '0;
      endcase
   end

   // Status read clears that cage's changed bits
   // The monitor acts on it at the edge that captures the word,
   // so the returned word still holds the old changed bits
   always_comb begin
      for (int n = 0; n < NUM_SFP; n++) begin
         o_sfp_clear[n] = i_rb_stb &&
                          (i_rb_addr == SET_AWIDTH'(RB_SFPP_STATUS0 + n));
      end
   end

   // --------------------
   // Read data register
   // --------------------
   // One result per strobe, one cycle later
   always_ff @(posedge clk) begin
      if (reset) begin
         o_rb_valid <= 1'b0;
      end else begin
         o_rb_valid <= i_rb_stb;
      end
   end

   // Word holds until the next strobe
   always_ff @(posedge clk) begin
      if (i_rb_stb) begin
         o_rb_data <= rb_word;
      end
   end

endmodule

/* hw/bus_int_top.sv */
/*
 * Board bus housekeeping top
 * Settings bank, SFP+ monitors, FIFO fault record and readback port
 */
`timescale 1ns/1ns

module bus_int_top (
   input  logic                                                clk,
   input  logic                                                reset,
   // Settings bus
   input  bus_int_pkg::set_bus_t                               i_set,
   // Readback bus
   input  logic                                                i_rb_stb,
   input  logic [bus_int_pkg::SET_AWIDTH-1:0]                  i_rb_addr,
   output logic                                                o_rb_valid,
   output logic [bus_int_pkg::SET_DWIDTH-1:0]                  o_rb_data,
   // Board status inputs
   input  logic [bus_int_pkg::CLK_STATUS_W-1:0]                i_clock_status,
   input  bus_int_pkg::sfp_pins_t [bus_int_pkg::NUM_SFP-1:0]   i_sfp_pins,
   input  logic [bus_int_pkg::FIFO_FLAG_W-1:0]                 i_fifo_flags_n,
   // Control outputs
   output logic [bus_int_pkg::LED_W-1:0]                       o_leds,
   output logic [bus_int_pkg::SW_RST_W-1:0]                    o_sw_rst,
   output logic [bus_int_pkg::CLK_CTRL_W-1:0]                  o_clock_control,
   output logic [bus_int_pkg::NUM_SFP-1:0][1:0]                o_sfpp_rs_drive_low
);

   import bus_int_pkg::*;

   logic                             fifo_clear;
   logic [FIFO_FLAG_W-1:0]           fifo_flags;
   logic [NUM_SFP-1:0]               sfp_clear;
   sfp_status_t [NUM_SFP-1:0]        sfp_status;

   // --------------------
   // Settings side
   // --------------------
   settings_regs settings_regs_i (
      .clk                 (clk),
      .reset               (reset),
      .i_set               (i_set),
      .o_leds              (o_leds),
      .o_sw_rst            (o_sw_rst),
      .o_clock_control     (o_clock_control),
      .o_sfpp_rs_drive_low (o_sfpp_rs_drive_low),
      .o_fifo_clear        (fifo_clear)
   );

   // One monitor per cage
   for (genvar n = 0; n < NUM_SFP; n++) begin : g_sfp
      sfp_status_monitor sfp_status_monitor_i (
         .clk      (clk),
         .reset    (reset),
         .i_pins   (i_sfp_pins[n]),
         .i_clear  (sfp_clear[n]),
         .o_status (sfp_status[n])
      );
   end

   // Cleared by a settings write
   fault_flag_accum fault_flag_accum_i (
      .clk            (clk),
      .reset          (reset),
      .i_fifo_flags_n (i_fifo_flags_n),
      .i_clear        (fifo_clear),
      .o_flags        (fifo_flags)
   );

   // --------------------
   // Readback side
   // --------------------
   readback_mux readback_mux_i (
      .clk            (clk),
      .reset          (reset),
      .i_rb_stb       (i_rb_stb),
      .i_rb_addr      (i_rb_addr),
      .i_clock_status (i_clock_status),
      .i_sfp_status   (sfp_status),
      .i_fifo_flags   (fifo_flags),
      .o_rb_valid     (o_rb_valid),
      .o_rb_data      (o_rb_data),
      .o_sfp_clear    (sfp_clear)
   );

endmodule

/* testbench/tb_bus_int.sv */
/*
 * Testbench for the board bus housekeeping top
 * Settings writes, readback decode, SFP+ status and FIFO fault record
 */
`timescale 1ns/1ns

module tb_bus_int;

   import bus_int_pkg::*;

   localparam int CLK_PERIOD      = 100;
   localparam int ROUNDS          = 4;
   localparam int RB_TIMEOUT      = 10;
   // Reset and compat read, then the per round work of each test
   localparam int PLANNED_OPS     = 2 + ROUNDS * (6 + 5 + 4 * NUM_SFP + 7);
   localparam int WATCHDOG_CYCLES = 20 * PLANNED_OPS + 200;

   logic                    clk = 1'b0;
   logic                    reset;
   set_bus_t                set_bus;
   logic                    rb_stb;
   logic [SET_AWIDTH-1:0]   rb_addr;
   logic                    rb_valid;
   logic [SET_DWIDTH-1:0]   rb_data;
   logic [CLK_STATUS_W-1:0] clock_status;
   sfp_pins_t [NUM_SFP-1:0] sfp_pins;
   logic [FIFO_FLAG_W-1:0]  fifo_flags_n;
   logic [LED_W-1:0]        leds;
   logic [SW_RST_W-1:0]     sw_rst;
   logic [CLK_CTRL_W-1:0]   clock_control;
   logic [NUM_SFP-1:0][1:0] sfpp_rs_drive_low;

   // Expected control register contents
   logic [LED_W-1:0]        exp_leds;
   logic [SW_RST_W-1:0]     exp_sw_rst;
   logic [CLK_CTRL_W-1:0]   exp_clk_ctrl;
   logic [NUM_SFP-1:0][1:0] exp_drive;

   int    cycle_count = 0;
   int    release_cycle;
   int    check_errors = 0;
   int    test_start_errors;
   int    tests_passed = 0;
   int    tests_failed = 0;
   string test_name;

   bus_int_top bus_int_top_i (
      .clk                 (clk),
      .reset               (reset),
      .i_set               (set_bus),
      .i_rb_stb            (rb_stb),
      .i_rb_addr           (rb_addr),
      .o_rb_valid          (rb_valid),
      .o_rb_data           (rb_data),
      .i_clock_status      (clock_status),
      .i_sfp_pins          (sfp_pins),
      .i_fifo_flags_n      (fifo_flags_n),
      .o_leds              (leds),
      .o_sw_rst            (sw_rst),
      .o_clock_control     (clock_control),
      .o_sfpp_rs_drive_low (sfpp_rs_drive_low)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Rising edges seen so far
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   // --------------------
   // Check and bus tasks
   // --------------------
   task automatic check_value(input string label, input logic [SET_DWIDTH-1:0] expected,
                              input logic [SET_DWIDTH-1:0] actual);
      assert (actual === expected) else begin
         $display("[FAIL] %s %s expected 0x%08h actual 0x%08h",
                  test_name, label, expected, actual);
         check_errors++;
      end
   endtask

   task automatic check_controls();
      check_value("leds", 32'(exp_leds), 32'(leds));
      check_value("sw_rst", 32'(exp_sw_rst), 32'(sw_rst));
      check_value("clock_control", 32'(exp_clk_ctrl), 32'(clock_control));
      check_value("sfpp_rs_drive_low", 32'(exp_drive), 32'(sfpp_rs_drive_low));
   endtask

   task automatic start_test(input string name);
      test_name         = name;
      test_start_errors = check_errors;
   endtask

   task automatic finish_test();
      if (check_errors == test_start_errors) begin
         tests_passed++;
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d checks failed", test_name, check_errors - test_start_errors);
      end
   endtask

   // Strobe for one cycle, outputs settle by the next falling edge
   task automatic write_setting(input logic [SET_AWIDTH-1:0] addr,
                                input logic [SET_DWIDTH-1:0] data);
      @(negedge clk);
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      @(negedge clk);
      set_bus.stb  = 1'b0;
   endtask

   // Each mapped register takes the low bits of its word
   task automatic apply_write(input logic [SET_AWIDTH-1:0] addr,
                              input logic [SET_DWIDTH-1:0] data);
      write_setting(addr, data);
      case (addr)
         SR_LEDS:       exp_leds     = data[LED_W-1:0];
         SR_SW_RST:     exp_sw_rst   = data[SW_RST_W-1:0];
         SR_CLOCK_CTRL: exp_clk_ctrl = data[CLK_CTRL_W-1:0];
         SR_SFPP_CTRL0: exp_drive[0] = data[1:0];
         SR_SFPP_CTRL1: exp_drive[1] = data[1:0];
         default: begin
         end
      endcase
      check_controls();
   endtask

   // Stamp is the cycle count when the strobe goes out
   task automatic read_register(input logic [SET_AWIDTH-1:0] addr,
                                output logic [SET_DWIDTH-1:0] data, output int stamp);
      int waited;
      @(negedge clk);
      rb_stb  = 1'b1;
      rb_addr = addr;
      stamp   = cycle_count;
      @(negedge clk);
      rb_stb  = 1'b0;
      waited  = 1;
      while (!rb_valid && waited < RB_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      assert (rb_valid) else begin
         $display("Readback of address %0d in %s never returned valid", addr, test_name);
         check_errors++;
      end
      check_value("rb_latency", 32'd1, 32'(waited));
      data = rb_valid ? rb_data : '0;
   endtask

   // --------------------
   // Watchdog
   // --------------------
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Result: FAILED");
      $finish;
   end

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      logic [SET_DWIDTH-1:0]  word;
      logic [SET_DWIDTH-1:0]  word2;
      logic [SET_AWIDTH-1:0]  addr;
      logic [2:0]             toggle;
      logic [FIFO_FLAG_W-1:0] pulse;
      logic [FIFO_FLAG_W-1:0] fifo_model;
      int                     stamp;
      int                     stamp2;
      int                     gap;
      int                     other;

      void'($urandom(32'hc1406002));
      reset        = 1'b1;
      set_bus      = '0;
      rb_stb       = 1'b0;
      rb_addr      = '0;
      clock_status = '0;
      sfp_pins     = '0;
      fifo_flags_n = '1;
      exp_leds     = '0;
      exp_sw_rst   = '0;
      exp_clk_ctrl = CLK_CTRL_RESET;
      exp_drive    = '0;
      fifo_model   = '0;
      repeat (5) @(negedge clk);
      reset         = 1'b0;
      release_cycle = cycle_count;

      start_test("reset_defaults");
      check_controls();
      check_value("rb_valid", 32'd0, 32'(rb_valid));
      read_register(RB_COMPAT_NUM, word, stamp);
      check_value("compat_num", {COMPAT_MAJOR, COMPAT_MINOR}, word);
      finish_test();

      start_test("settings_writes");
      for (int r = 0; r < ROUNDS; r++) begin
         apply_write(SR_LEDS, $urandom);
         apply_write(SR_SW_RST, $urandom);
         apply_write(SR_CLOCK_CTRL, $urandom);
         apply_write(SR_SFPP_CTRL0, $urandom);
         apply_write(SR_SFPP_CTRL1, $urandom);
         // Gap inside the map, then space above it
         addr = (r % 2 == 0) ? 8'(3 + $urandom % 5) : 8'(11 + $urandom % 245);
         apply_write(addr, $urandom);
      end
      finish_test();

      start_test("readback_decode");
      for (int r = 0; r < ROUNDS; r++) begin
         @(negedge clk);
         clock_status = CLK_STATUS_W'($urandom);
         read_register(RB_CLK_STATUS, word, stamp);
         check_value("clk_status", 32'(clock_status), word);
         addr = (r % 2 == 0) ? 8'(1 + $urandom % 2) : 8'(11 + $urandom % 245);
         read_register(addr, word, stamp);
         check_value("unused_addr", 32'd0, word);
         // Counter starts at zero on the first edge out of reset
         read_register(RB_COUNTER, word, stamp);
         check_value("counter", 32'(stamp - release_cycle), word);
         gap = 1 + $urandom % 8;
         repeat (gap) @(negedge clk);
         read_register(RB_COUNTER, word2, stamp2);
         check_value("counter_step", 32'(stamp2 - stamp), word2 - word);
      end
      finish_test();

      start_test("sfp_status");
      for (int r = 0; r < ROUNDS; r++) begin
         for (int c = 0; c < NUM_SFP; c++) begin
            other  = (c + 1) % NUM_SFP;
            toggle = 3'(1 + $urandom % 7);
            @(negedge clk);
            sfp_pins[c] = sfp_pins_t'(sfp_pins[c] ^ toggle);
            repeat (4) @(negedge clk);
            read_register(8'(RB_SFPP_STATUS0 + c), word, stamp);
            check_value("status_changed", {26'd0, toggle, sfp_pins[c]}, word);
            // First read cleared the changed bits
            read_register(8'(RB_SFPP_STATUS0 + c), word, stamp);
            check_value("status_cleared", {26'd0, 3'd0, sfp_pins[c]}, word);
            read_register(8'(RB_SFPP_STATUS0 + other), word, stamp);
            check_value("other_cage", {26'd0, 3'd0, sfp_pins[other]}, word);
         end
      end
      finish_test();

      start_test("fifo_fault_record");
      for (int r = 0; r < ROUNDS; r++) begin
         repeat (2) begin
            pulse = 4'(1 + $urandom % 15);
            @(negedge clk);
            fifo_flags_n = ~pulse;
            @(negedge clk);
            fifo_flags_n = '1;
            fifo_model   = fifo_model | pulse;
            read_register(RB_FIFOFLAGS, word, stamp);
            check_value("fifo_flags", 32'(fifo_model), word);
         end
         // Clear lands one edge after the write is taken
         apply_write(SR_FIFOFLAGS, $urandom);
         @(negedge clk);
         fifo_model = '0;
         read_register(RB_FIFOFLAGS, word, stamp);
         check_value("fifo_flags_cleared", 32'd0, word);
      end
      finish_test();

      $display("Tests passed: %0d  failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* src.f */
hw/bus_int_pkg.sv
hw/settings_regs.sv
hw/sfp_status_monitor.sv
hw/fault_flag_accum.sv
hw/readback_mux.sv
hw/bus_int_top.sv
testbench/tb_bus_int.sv

/* Makefile */
# Verilator build and run of the board bus housekeeping testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_bus_int
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
